//--- all.f
source/fdd_pkg.sv
source/fdd_buf_if.sv
source/fdd_byte_if.sv
source/sector_buffer_wb.sv
source/crc16_ccitt.sv
source/track_formatter.sv
source/mfm_encoder.sv
source/fdd_emulator_top.sv
test/tb_clock_gen.sv
test/fdd_emulator_checker.sv
test/fdd_emulator_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fdd_emulator_tb -f all.f -o sim_fdd

./obj_dir/sim_fdd | tee sim.log

grep -q "^test passed$" sim.log
echo "simulation ok"

//--- source/crc16_ccitt.sv
`timescale 1ns/1ps

module crc16_ccitt
    import fdd_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  logic        feed,
    input  logic  [7:0] data_in,
    output logic [15:0] crc
);

    // one byte, msb first.
    function automatic logic [15:0] crc_fold(input logic [15:0] c, input logic [7:0] d);
        logic [15:0] r;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            if (r[15] ^ d[i]) begin
                r = {r[14:0], 1'b0} ^ CRC_POLY;
            end else begin
                r = {r[14:0], 1'b0};
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            crc <= CRC_INIT;
        end else if (clear) begin
            crc <= crc_fold(CRC_INIT, data_in);   // first A1 counts.
        end else if (feed) begin
            crc <= crc_fold(crc, data_in);
        end
    end

endmodule

//--- source/fdd_buf_if.sv
`timescale 1ns/1ps

interface fdd_buf_if;

    logic [12:0] buf_addr;   // sector * 512 + offset.
    logic  [7:0] buf_q;      // one cycle behind buf_addr.

    // control register values.
    logic  [6:0] track;
    logic        side;
    logic        ready;

    modport buffer (
        input  buf_addr,
        output buf_q, track, side, ready
    );

    modport formatter (
        output buf_addr,
        input  buf_q, track, side, ready
    );

endinterface

//--- source/fdd_byte_if.sv
`timescale 1ns/1ps

interface fdd_byte_if;

    logic       take;        // encoder consumes current byte.
    logic [7:0] byte_data;
    logic       is_sync;     // sync byte, missing clock bit.
    logic       index;

    modport formatter (
        input  take,
        output byte_data,
        output is_sync,
        output index
    );

    modport encoder (
        output take,
        input  byte_data,
        input  is_sync,
        input  index
    );

endinterface

//--- source/fdd_emulator_top.sv
`timescale 1ns/1ps

module fdd_emulator_top #(
    parameter int cell_cycles = 2
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [13:0] wb_adr,
    input  logic  [7:0] wb_dat_w,
    output logic  [7:0] wb_dat_r,
    output logic        wb_ack,
    output logic        rd_data,
    output logic        index_n
);

    fdd_buf_if  buf_bus ();
    fdd_byte_if bytes ();

    // host side.
    sector_buffer_wb buffer_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .buf_bus  (buf_bus)
    );

    track_formatter formatter_i (
        .clk     (clk),
        .reset   (reset),
        .buf_bus (buf_bus),
        .bytes   (bytes)
    );

    // head side.
    mfm_encoder #(
        .cell_cycles (cell_cycles)
    ) encoder_i (
        .clk     (clk),
        .reset   (reset),
        .bytes   (bytes),
        .rd_data (rd_data),
        .index_n (index_n)
    );

endmodule

//--- source/fdd_pkg.sv
package fdd_pkg;

    // formatter field.
    typedef enum logic [1:0] {
        HEADER,
        SECTORS,
        GAPS,
        IDLE
    } track_field_t;

    // ####################
    // track layout, in bytes
    localparam int HEADER_LEN        = 146;
    localparam int SECTOR_LEN        = 658;
    localparam int GAP_LEN           = 182;
    localparam int SECTORS_PER_TRACK = 9;
    localparam int SECTOR_BYTES      = 512;
    localparam int DATA_START        = 60;   // first data byte in a sector.
    localparam int ID_CRC_POS        = 20;
    localparam int DATA_CRC_POS      = 572;

    // mark and fill bytes.
    localparam logic [7:0] FILL_BYTE = 8'h4E;
    localparam logic [7:0] IAM_SYNC  = 8'hC2;
    localparam logic [7:0] IAM_MARK  = 8'hFC;
    localparam logic [7:0] AM_SYNC   = 8'hA1;
    localparam logic [7:0] IDAM_MARK = 8'hFE;
    localparam logic [7:0] DAM_MARK  = 8'hFB;
    localparam logic [7:0] SIZE_CODE = 8'h02;   // 512 byte sectors.

    // ####################
    // wishbone register map
    localparam int          BUF_LIMIT = 4608;
    localparam logic [13:0] REG_TRACK = 14'h2000;
    localparam logic [13:0] REG_CTRL  = 14'h2001;

    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'h1021;

endpackage

//--- source/mfm_encoder.sv
`timescale 1ns/1ps

module mfm_encoder
    import fdd_pkg::*;
#(
    parameter int cell_cycles = 2
)
(
    input  logic        clk,
    input  logic        reset,
    fdd_byte_if.encoder bytes,
    output logic        rd_data,
    output logic        index_n
);

    localparam int CNT_W = (cell_cycles > 1) ? $clog2(cell_cycles) : 1;

    logic [CNT_W-1:0] cell_cnt;
    logic             cell_tick;
    logic       [3:0] cell_idx;
    logic      [15:0] shift_reg;   // clock and data cells, first cell at msb.
    logic             last_bit;
    logic             cur_index;

    function automatic logic [15:0] mfm_word(input logic [7:0] d, input logic sync,
                                             input logic prev);
        logic [15:0] w;
        logic        p;
        p = prev;
        for (int i = 7; i >= 0; i--) begin
            w[2*i+1] = ~(p | d[i]);
            w[2*i]   = d[i];
            p        = d[i];
        end
        // missing clock. C2 between bits 4 and 3, A1 between bits 3 and 2.
        if (sync) begin
            if (d == IAM_SYNC) begin
                w[7] = 1'b0;
            end else begin
                w[5] = 1'b0;
            end
        end
        return w;
    endfunction

    assign cell_tick  = cell_cnt == CNT_W'(cell_cycles - 1);
    assign bytes.take = cell_tick && cell_idx == 4'd15;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cell_cnt <= '0;
        end else if (cell_tick) begin
            cell_cnt <= '0;
        end else begin
            cell_cnt <= cell_cnt + 1'b1;
        end
    end

    // ####################
    // cell shifter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cell_idx  <= '0;
            shift_reg <= mfm_word(FILL_BYTE, 1'b0, 1'b0);
            last_bit  <= FILL_BYTE[0];
            cur_index <= 1'b0;
            rd_data   <= 1'b0;
            index_n   <= 1'b1;
        end else if (cell_tick) begin
            rd_data  <= shift_reg[15];
            cell_idx <= cell_idx + 4'd1;   // wraps after 16 cells.
            if (cell_idx == 4'd0) begin
                index_n <= ~cur_index;   // aligned with first cell.
            end
            if (bytes.take) begin
                shift_reg <= mfm_word(bytes.byte_data, bytes.is_sync, last_bit);
                last_bit  <= bytes.byte_data[0];
                cur_index <= bytes.index;
            end else begin
                shift_reg <= {shift_reg[14:0], 1'b0};
            end
        end
    end

endmodule

//--- source/sector_buffer_wb.sv
`timescale 1ns/1ps

module sector_buffer_wb
    import fdd_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [13:0] wb_adr,
    input  logic  [7:0] wb_dat_w,
    output logic  [7:0] wb_dat_r,
    output logic        wb_ack,
    fdd_buf_if.buffer   buf_bus
);

    logic [7:0] mem [BUF_LIMIT];

    logic       wb_hit;
    logic       ram_sel;
    logic [6:0] track_r;
    logic       side_r;
    logic       ready_r;

    // sampled access, ack follows one cycle later.
    assign wb_hit  = wb_cyc && wb_stb && !wb_ack;
    assign ram_sel = wb_adr < 14'(BUF_LIMIT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack  <= 1'b0;
            track_r <= '0;
            side_r  <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            wb_ack <= wb_hit;
            if (wb_hit && wb_we) begin
                if (wb_adr == REG_TRACK) begin
                    track_r <= wb_dat_w[6:0];
                end
                if (wb_adr == REG_CTRL) begin
                    side_r  <= wb_dat_w[0];
                    ready_r <= wb_dat_w[1];
                end
            end
        end
    end

    // sector space reads back as zero.
    always_ff @(posedge clk) begin
        if (wb_hit && !wb_we) begin
            case (wb_adr)
                REG_TRACK: wb_dat_r <= {1'b0, track_r};
                REG_CTRL:  wb_dat_r <= {6'd0, ready_r, side_r};
                default:   wb_dat_r <= 8'h00;
            endcase
        end
    end

    // ####################
    // sector ram
    always_ff @(posedge clk) begin
        if (wb_hit && wb_we && ram_sel) begin
            mem[wb_adr[12:0]] <= wb_dat_w;
        end
    end

    always_ff @(posedge clk) begin
        buf_bus.buf_q <= mem[buf_bus.buf_addr];   // formatter read port.
    end

    assign buf_bus.track = track_r;
    assign buf_bus.side  = side_r;
    assign buf_bus.ready = ready_r;

endmodule

//--- source/track_formatter.sv
`timescale 1ns/1ps

module track_formatter
    import fdd_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    fdd_buf_if.formatter  buf_bus,
    fdd_byte_if.formatter bytes
);

    track_field_t field;
    logic  [12:0] track_position;
    logic   [3:0] sector;
    logic   [6:0] track_s;
    logic         side_s;
    logic         take_d;

    logic   [7:0] next_byte;
    logic         next_sync;
    logic         next_index;
    logic  [12:0] data_offset;
    logic         crc_clear;
    logic         crc_feed;
    logic  [15:0] crc;

    // ####################
    // layout walk
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            field          <= IDLE;
            track_position <= '0;
            sector         <= '0;
            track_s        <= '0;
            side_s         <= 1'b0;
        end else if (bytes.take) begin
            track_s        <= buf_bus.track;
            side_s         <= buf_bus.side;
            track_position <= track_position + 13'd1;
            if (!buf_bus.ready) begin
                field          <= IDLE;
                track_position <= '0;
            end else begin
                case (field)
                    IDLE: begin
                        field          <= HEADER;
                        track_position <= '0;
                    end
                    HEADER: begin
                        if (track_position == HEADER_LEN - 1) begin
                            field          <= SECTORS;
                            track_position <= '0;
                            sector         <= '0;
                        end
                    end
                    SECTORS: begin
                        if (track_position == SECTOR_LEN - 1) begin
                            track_position <= '0;
                            if (sector == SECTORS_PER_TRACK - 1) begin
                                field <= GAPS;
                            end else begin
                                sector <= sector + 4'd1;
                            end
                        end
                    end
                    GAPS: begin
                        if (track_position == GAP_LEN - 1) begin
                            field          <= HEADER;
                            track_position <= '0;
                        end
                    end
                endcase
            end
        end
    end

    // ram is read one byte ahead, so buf_q is ready when the byte is built.
    assign data_offset      = track_position - 13'(DATA_START - 1);
    assign buf_bus.buf_addr = (field == SECTORS && track_position >= DATA_START - 1
                               && track_position < DATA_CRC_POS - 1)
                              ? 13'(sector) * 13'(SECTOR_BYTES) + data_offset : '0;

    // ####################
    // byte table
    always_comb begin
        next_byte  = FILL_BYTE;
        next_sync  = 1'b0;
        next_index = 1'b0;
        case (field)
            HEADER: begin
                next_index = track_position >= 80 && track_position < 96;
                if (track_position >= 80 && track_position < 92) begin
                    next_byte = 8'h00;
                end else if (track_position >= 92 && track_position < 95) begin
                    next_byte = IAM_SYNC;
                    next_sync = 1'b1;
                end else if (track_position == 95) begin
                    next_byte = IAM_MARK;
                end
            end
            SECTORS: begin
                if (track_position < 12) begin
                    next_byte = 8'h00;
                end else if (track_position < 15) begin
                    next_byte = AM_SYNC;
                    next_sync = 1'b1;
                end else if (track_position < 16) begin
                    next_byte = IDAM_MARK;
                end else if (track_position < 17) begin
                    next_byte = {1'b1, track_s};
                end else if (track_position < 18) begin
                    next_byte = {7'd0, side_s};
                end else if (track_position < 19) begin
                    next_byte = {4'd0, sector};
                end else if (track_position < ID_CRC_POS) begin
                    next_byte = SIZE_CODE;
                end else if (track_position == ID_CRC_POS) begin
                    next_byte = crc[15:8];
                end else if (track_position == ID_CRC_POS + 1) begin
                    next_byte = crc[7:0];
                end else if (track_position < 44) begin
                    next_byte = FILL_BYTE;
                end else if (track_position < 56) begin
                    next_byte = 8'h00;
                end else if (track_position < 59) begin
                    next_byte = AM_SYNC;
                    next_sync = 1'b1;
                end else if (track_position < DATA_START) begin
                    next_byte = DAM_MARK;
                end else if (track_position < DATA_CRC_POS) begin
                    next_byte = buf_bus.buf_q;
                end else if (track_position == DATA_CRC_POS) begin
                    next_byte = crc[15:8];
                end else if (track_position == DATA_CRC_POS + 1) begin
                    next_byte = crc[7:0];
                end
            end
            default: ;   // gap and idle are fill.
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            take_d          <= 1'b0;
            bytes.byte_data <= FILL_BYTE;
            bytes.is_sync   <= 1'b0;
            bytes.index     <= 1'b0;
        end else begin
            take_d <= bytes.take;
            if (take_d) begin
                bytes.byte_data <= next_byte;
                bytes.is_sync   <= next_sync;
                bytes.index     <= next_index;
            end
        end
    end

    // crc runs over the taken bytes, from the first A1 to the last field byte.
    assign crc_clear = bytes.take && field == SECTORS
                       && (track_position == 12 || track_position == 56);
    assign crc_feed  = bytes.take && field == SECTORS
                       && ((track_position > 12 && track_position < ID_CRC_POS)
                           || (track_position > 56 && track_position < DATA_CRC_POS));

    crc16_ccitt crc_i (
        .clk     (clk),
        .reset   (reset),
        .clear   (crc_clear),
        .feed    (crc_feed),
        .data_in (bytes.byte_data),
        .crc     (crc)
    );

endmodule

//--- test/fdd_emulator_checker.sv
`timescale 1ns/1ps

module fdd_emulator_checker #(
    parameter int cell_cycles = 2
)
(
    input logic       clk,
    input logic       reset,
    input logic       wb_ack,
    input logic       index_n,
    input logic       ready,
    input logic       take,
    input logic [7:0] byte_data
);

    logic [15:0] since_take;   // cycles since the last take.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_take <= 16'hffff;
        end else if (take) begin
            since_take <= '0;
        end else if (since_take != 16'hffff) begin
            since_take <= since_take + 16'd1;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack) else $error("wb_ack high in two cycles");

    a_index_idle: assert property (@(posedge clk) disable iff (reset)
        !ready |-> index_n) else $error("index_n low while not ready");

    a_take_spacing: assert property (@(posedge clk) disable iff (reset)
        take |-> since_take >= 16'(16 * cell_cycles - 1)) else $error("take too early");

    // byte settles two cycles after take.
    a_byte_stable: assert property (@(posedge clk) disable iff (reset)
        (since_take >= 16'd2 && since_take != 16'hffff) |-> $stable(byte_data))
        else $error("byte_data changed between takes");

endmodule

bind fdd_emulator_top fdd_emulator_checker #(
    .cell_cycles (cell_cycles)
) checker_i (
    .clk       (clk),
    .reset     (reset),
    .wb_ack    (wb_ack),
    .index_n   (index_n),
    .ready     (buf_bus.ready),
    .take      (bytes.take),
    .byte_data (bytes.byte_data)
);

//--- test/fdd_emulator_tb.sv
`timescale 1ns/1ps

module fdd_emulator_tb;

    localparam int CELL_CYCLES = 2;
    localparam int TRACK_BYTES = 6250;
    localparam int TIMEOUT     = 2 * TRACK_BYTES * 16 * CELL_CYCLES + 1000;

    typedef struct packed {
        logic  [6:0] track;
        logic        side;
        logic [31:0] seed;
        logic  [7:0] exp_track;
        logic  [7:0] exp_ctrl;
    } stim_t;

    // second entry changes track and side while the track runs.
    stim_t stim_table [2] = '{
        '{7'd79, 1'b1, 32'd0, 8'h4f, 8'h03},
        '{7'd12, 1'b0, 32'd5, 8'h0c, 8'h02}
    };

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [13:0] wb_adr;
    logic  [7:0] wb_dat_w;
    logic  [7:0] wb_dat_r;
    logic        wb_ack;
    logic        rd_data;
    logic        index_n;

    logic [7:0] model [4608];
    logic [7:0] exp_byte [TRACK_BYTES];
    logic       exp_sync [TRACK_BYTES];
    int         exp_len;
    logic [15:0] cur_crc;
    int         errors = 0;
    integer     seed;

    tb_clock_gen clock_i (
        .clk   (clk),
        .reset (reset)
    );

    fdd_emulator_top #(
        .cell_cycles (CELL_CYCLES)
    ) fdd_emulator_top_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rd_data  (rd_data),
        .index_n  (index_n)
    );

    // ####################
    // checks and models
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [7:0] b);
        logic [15:0] r;
        r = c ^ {b, 8'h00};
        for (int i = 0; i < 8; i++) begin
            r = r[15] ? ((r << 1) ^ 16'h1021) : (r << 1);
        end
        return r;
    endfunction

    // clock cell set only between two zero data bits.
    function automatic logic [15:0] mfm_cells(input logic [7:0] d, input logic prev);
        logic [15:0] w;
        for (int i = 7; i >= 0; i--) begin
            w[2*i]   = d[i];
            w[2*i+1] = (i == 7) ? !(prev || d[7]) : !(d[i+1] || d[i]);
        end
        return w;
    endfunction

    function automatic logic [7:0] data_bits(input logic [15:0] w);
        logic [7:0] d;
        for (int i = 0; i < 8; i++) begin
            d[i] = w[2*i];
        end
        return d;
    endfunction

    task automatic put_byte(input logic [7:0] b, input logic s);
        exp_byte[exp_len] = b;
        exp_sync[exp_len] = s;
        exp_len++;
    endtask

    task automatic put_crc(input logic [7:0] b, input logic s);
        put_byte(b, s);
        cur_crc = crc_step(cur_crc, b);
    endtask

    task automatic build_expected(input logic [6:0] trk, input logic side);
        exp_len = 0;
        repeat (80) put_byte(8'h4e, 1'b0);
        repeat (12) put_byte(8'h00, 1'b0);
        repeat (3) put_byte(8'hc2, 1'b1);
        put_byte(8'hfc, 1'b0);
        repeat (50) put_byte(8'h4e, 1'b0);
        for (int s = 0; s < 9; s++) begin
            repeat (12) put_byte(8'h00, 1'b0);
            cur_crc = 16'hffff;
            repeat (3) put_crc(8'ha1, 1'b1);
            put_crc(8'hfe, 1'b0);
            put_crc({1'b1, trk}, 1'b0);
            put_crc({7'd0, side}, 1'b0);
            put_crc(8'(s), 1'b0);
            put_crc(8'h02, 1'b0);
            put_byte(cur_crc[15:8], 1'b0);
            put_byte(cur_crc[7:0], 1'b0);
            repeat (22) put_byte(8'h4e, 1'b0);
            repeat (12) put_byte(8'h00, 1'b0);
            cur_crc = 16'hffff;
            repeat (3) put_crc(8'ha1, 1'b1);
            put_crc(8'hfb, 1'b0);
            for (int k = 0; k < 512; k++) begin
                put_crc(model[s*512+k], 1'b0);
            end
            put_byte(cur_crc[15:8], 1'b0);
            put_byte(cur_crc[7:0], 1'b0);
            repeat (84) put_byte(8'h4e, 1'b0);
        end
        repeat (182) put_byte(8'h4e, 1'b0);
    endtask

    // ####################
    // wishbone access
    task automatic wb_access(input logic we, input logic [13:0] adr, input logic [7:0] dat);
        int n;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        while (1) begin
            @(posedge clk);
            #1;
            n++;
            if (wb_ack) break;
            if (n > 20) report_timeout("wb_ack");
        end
        check_value("wb_ack latency", n, 1);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // ####################
    // stream capture
    task automatic read_byte(output logic [15:0] word, output logic idx_n);
        word = '0;
        for (int c = 0; c < 16; c++) begin
            if (c == 0) idx_n = index_n;
            word = {word[14:0], rd_data};
            repeat (CELL_CYCLES) @(negedge clk);
        end
    endtask

    task automatic wait_index_fall();
        logic prev;
        int   n;
        @(negedge clk);
        prev = index_n;
        n = 0;
        while (1) begin
            @(negedge clk);
            if (!index_n && prev) break;
            prev = index_n;
            n++;
            if (n > TIMEOUT) report_timeout("index_n to fall");
        end
    endtask

    task automatic check_not_ready();
        bit          cells[$];
        logic [15:0] fill_word;
        logic [15:0] win;
        bit          found;
        bit          match;
        int          n;
        fill_word = mfm_cells(8'h4e, 1'b0);
        n = 0;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
            n++;
            if (n > 100) report_timeout("reset release");
        end
        repeat (64 * CELL_CYCLES) @(negedge clk);
        for (int j = 0; j < 200 * 16; j++) begin
            check_value("index_n while not ready", index_n, 1);
            cells.push_back(rd_data);
            repeat (CELL_CYCLES) @(negedge clk);
        end
        win = '0;
        for (int j = 0; j < cells.size(); j++) begin
            win = {win[14:0], cells[j]};
            if (j >= 15) begin
                check_value("no sync while not ready",
                            win == 16'h4489 || win == 16'h5224, 0);
            end
        end
        found = 0;
        for (int k = 0; k < 16; k++) begin
            match = 1;
            for (int j = 0; j < cells.size(); j++) begin
                if (cells[j] != fill_word[15 - ((j + k) % 16)]) match = 0;
            end
            if (match) found = 1;
        end
        check_value("idle stream decodes as 4E", found, 1);
    endtask

    task automatic check_track();
        logic [15:0] word;
        logic        idx_n;
        int          e;
        int          p;
        wait_index_fall();
        for (int i = 0; i < TRACK_BYTES; i++) begin
            read_byte(word, idx_n);
            e = (80 + i) % TRACK_BYTES;
            p = (e + TRACK_BYTES - 1) % TRACK_BYTES;
            check_value($sformatf("rd_data byte %0d", e), data_bits(word), exp_byte[e]);
            check_value($sformatf("index_n byte %0d", e), idx_n, (i < 16) ? 0 : 1);
            if (exp_sync[e]) begin
                check_value($sformatf("sync cells byte %0d", e), word,
                            (exp_byte[e] == 8'ha1) ? 16'h4489 : 16'h5224);
            end else begin
                check_value($sformatf("mfm cells byte %0d", e), word,
                            mfm_cells(exp_byte[e], exp_byte[p][0]));
            end
        end
    endtask

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;

        check_not_ready();

        foreach (stim_table[t]) begin
            seed = 32'hdfbe + stim_table[t].seed;
            for (int a = 0; a < 4608; a++) begin
                model[a] = 8'($random(seed));
                wb_access(1'b1, 14'(a), model[a]);
            end
            wb_access(1'b1, 14'h2000, {1'b0, stim_table[t].track});
            wb_access(1'b1, 14'h2001, {6'd0, 1'b1, stim_table[t].side});
            wb_access(1'b0, 14'h2000, 8'h00);
            check_value("wb_dat_r track", wb_dat_r, stim_table[t].exp_track);
            wb_access(1'b0, 14'h2001, 8'h00);
            check_value("wb_dat_r ctrl", wb_dat_r, stim_table[t].exp_ctrl);
            build_expected(stim_table[t].track, stim_table[t].side);
            check_track();
        end

        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule
